/* rtl/audio_pkg.sv */
package audio_pkg;

    ////////////////////////////////////////////////////////////
    // Sample format
    ////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 16;                   // Bits per audio word

    typedef logic [SAMPLE_W-1:0] sample_t;          // Signed sample in two's complement

    // Index of a bit inside one serial word
    typedef logic [3:0] bit_cnt_t;

    ////////////////////////////////////////////////////////////
    // Moving average window
    ////////////////////////////////////////////////////////////

    localparam int AVG_TAPS = 4;                    // Frames per channel in the window
    localparam int TAP_W    = 2;                    // Tap index width and divide shift

    // Serial bit clock
    localparam int SCK_DIV = 8;                     // clk cycles per sck period, even only

endpackage

/* rtl/mem_pkg.sv */
package mem_pkg;

    // Left slots then right slots
    localparam int RAM_DEPTH = 2 * audio_pkg::AVG_TAPS;

    // History RAM address as {channel, slot}
    //   top bit   0 for left and 1 for right
    //   low bits  slot number of the frame
    typedef logic [$clog2(RAM_DEPTH)-1:0] ram_addr_t;

endpackage

/* rtl/sck_gen.sv */
`timescale 1ns/1ns

module sck_gen (
    input  logic clk,
    input  logic rst_n,
    output logic i2s_sck,
    output logic sck_rise
);

    import audio_pkg::*;

    typedef logic [$clog2(SCK_DIV)-1:0] div_cnt_t;

    div_cnt_t div_cnt;                              // Position inside one sck period

    // Low half first, high half after the wrap
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt  <= '0;
            i2s_sck  <= 1'b0;
            sck_rise <= 1'b0;
        end
        else
        begin
            sck_rise <= 1'b0;                       // Single cycle strobe
            if (div_cnt == div_cnt_t'(SCK_DIV - 1))
            begin
                div_cnt  <= '0;
                i2s_sck  <= 1'b1;                   // Rising edge of sck
                sck_rise <= 1'b1;                   // Marks the same edge
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
                if (div_cnt == div_cnt_t'(SCK_DIV / 2 - 1))
                    i2s_sck <= 1'b0;                // Falling edge at half period
            end
        end
    end

endmodule

/* rtl/i2si_deserializer.sv */
`timescale 1ns/1ns

module i2si_deserializer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sck_rise,
    input  logic               i2si_sd,
    input  logic               i2si_ws,
    output logic               wr_req,
    output mem_pkg::ram_addr_t wr_addr,
    output audio_pkg::sample_t wr_data,
    input  logic               wr_gnt,
    output logic               frame_done
);

    import audio_pkg::*;

    logic             ws_d;                         // ws from the previous sck rise
    logic             ws_edge;                      // Word boundary seen this rise
    logic             word_full;                    // 15 bits already in since last edge
    sample_t          shift_reg;                    // Serial to parallel shifter
    bit_cnt_t         bit_cnt;                      // Bits taken in the current word
    logic [TAP_W-1:0] slot;                         // History slot of the current frame

    // ws flips during the LSB of the old word
    assign ws_edge   = sck_rise && (i2si_ws != ws_d);
    assign word_full = (bit_cnt == bit_cnt_t'(SAMPLE_W - 1));

    ////////////////////////////////////////////////////////////
    // Serial side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ws_d    <= 1'b0;
            bit_cnt <= '0;
        end
        else if (sck_rise)
        begin
            ws_d <= i2si_ws;
            if (ws_edge)
                bit_cnt <= '0;                      // Next rise carries the MSB
            else if (!word_full)
                bit_cnt <= bit_cnt + 1'b1;          // Saturates while the line idles
        end
    end

    // MSB first into the bottom of the shifter
    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shift_reg <= {shift_reg[SAMPLE_W-2:0], i2si_sd};
        if (ws_edge && word_full)
            wr_data <= {shift_reg[SAMPLE_W-2:0], i2si_sd};  // Include the LSB now
    end

    ////////////////////////////////////////////////////////////
    // RAM write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_req     <= 1'b0;
            wr_addr    <= '0;
            slot       <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (ws_edge && word_full)
            begin
                wr_req  <= 1'b1;                    // Held until granted
                wr_addr <= {ws_d, slot};            // Channel of the finished word
            end
            else if (wr_gnt)
            begin
                wr_req <= 1'b0;
                if (wr_addr[TAP_W])                 // Right word closes the frame
                begin
                    frame_done <= 1'b1;
                    slot       <= (slot == TAP_W'(AVG_TAPS - 1)) ? '0 : slot + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/sample_ram_arb.sv */
`timescale 1ns/1ns

module sample_ram_arb (
    input  logic               clk,
    input  logic               rst_n,
    // Deserializer port
    input  logic               wr_req,
    input  mem_pkg::ram_addr_t wr_addr,
    input  audio_pkg::sample_t wr_data,
    output logic               wr_gnt,
    // Filter port
    input  logic               rd_req,
    input  mem_pkg::ram_addr_t rd_addr,
    output audio_pkg::sample_t rd_data,
    output logic               rd_gnt
);

    import audio_pkg::*;
    import mem_pkg::*;

    sample_t hist_mem [RAM_DEPTH];                  // Sample history of both channels

    ////////////////////////////////////////////////////////////
    // Fixed priority grant
    ////////////////////////////////////////////////////////////

    assign wr_gnt = wr_req;                         // Writer never waits
    assign rd_gnt = rd_req && !wr_req;              // Reader retries next cycle

    // Zero history so the first averages start from silence
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < RAM_DEPTH; i++)
                hist_mem[i] <= '0;
        end
        else if (wr_gnt)
        begin
            hist_mem[wr_addr] <= wr_data;
        end
    end

    // Read word valid one cycle after the grant
    always_ff @(posedge clk)
    begin
        if (rd_gnt)
            rd_data <= hist_mem[rd_addr];
    end

endmodule

/* rtl/avg_filter.sv */
`timescale 1ns/1ns

module avg_filter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_done,
    // History RAM read port
    output logic               rd_req,
    output mem_pkg::ram_addr_t rd_addr,
    input  logic               rd_gnt,
    input  audio_pkg::sample_t rd_data,
    // Serializer side
    output logic               filt_i2so_rts,
    output audio_pkg::sample_t filt_i2so_lft,
    output audio_pkg::sample_t filt_i2so_rgt,
    input  logic               filt_i2so_rtr
);

    import audio_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,                                    // Waiting for a new frame
        ST_READ,                                    // Request held until grant
        ST_ACC,                                     // Read word arrives here
        ST_DONE                                     // Both sums complete
    } state_t;

    state_t                           state;
    ram_addr_t                        idx;          // Slot being read
    logic signed [SAMPLE_W+TAP_W-1:0] rd_ext;       // Sign extended read word
    logic signed [SAMPLE_W+TAP_W-1:0] sum_l;
    logic signed [SAMPLE_W+TAP_W-1:0] sum_r;
    logic signed [SAMPLE_W+TAP_W-1:0] avg_l;
    logic signed [SAMPLE_W+TAP_W-1:0] avg_r;
    sample_t                          pend_l;       // Newest averages not yet offered
    sample_t                          pend_r;
    logic                             pending;

    assign rd_req  = (state == ST_READ);
    assign rd_addr = idx;
    assign rd_ext  = {{TAP_W{rd_data[SAMPLE_W-1]}}, rd_data};
    assign avg_l   = sum_l >>> TAP_W;               // Divide by AVG_TAPS with sign kept
    assign avg_r   = sum_r >>> TAP_W;

    ////////////////////////////////////////////////////////////
    // Read and sum all eight slots
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
            idx   <= '0;
            sum_l <= '0;
            sum_r <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (frame_done)
                    begin
                        idx   <= '0;
                        sum_l <= '0;
                        sum_r <= '0;
                        state <= ST_READ;
                    end
                end
                ST_READ:
                begin
                    if (rd_gnt)
                        state <= ST_ACC;
                end
                ST_ACC:
                begin
                    if (idx[TAP_W])                 // Upper half holds right samples
                        sum_r <= sum_r + rd_ext;
                    else
                        sum_l <= sum_l + rd_ext;
                    if (idx == ram_addr_t'(RAM_DEPTH - 1))
                        state <= ST_DONE;
                    else
                    begin
                        idx   <= idx + 1'b1;
                        state <= ST_READ;
                    end
                end
                ST_DONE:
                    state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Pending pair latched from the finished sums
    always_ff @(posedge clk)
    begin
        if (state == ST_DONE)
        begin
            pend_l <= avg_l[SAMPLE_W-1:0];
            pend_r <= avg_r[SAMPLE_W-1:0];
        end
    end

    // Handover to the serializer happens only on rtr
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending       <= 1'b0;
            filt_i2so_rts <= 1'b0;
            filt_i2so_lft <= '0;
            filt_i2so_rgt <= '0;
        end
        else
        begin
            if (filt_i2so_rtr && pending)
            begin
                filt_i2so_lft <= pend_l;            // Left and right move together
                filt_i2so_rgt <= pend_r;
                pending       <= 1'b0;
            end
            if (state == ST_DONE)
            begin
                pending       <= 1'b1;              // New result wins a same cycle rtr
                filt_i2so_rts <= 1'b1;              // Stays high from the first result
            end
        end
    end

endmodule

/* rtl/i2so_serializer.sv */
`timescale 1ns/1ns

module i2so_serializer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sck_transition,
    input  logic               filt_i2so_rts,
    output logic               filt_i2so_rtr,
    input  audio_pkg::sample_t filt_i2so_lft,
    input  audio_pkg::sample_t filt_i2so_rgt,
    output logic               i2so_sd,
    output logic               i2so_ws
);

    import audio_pkg::*;

    logic     active;                               // Set once and never cleared
    logic     rts_d;
    logic     rts_rise;
    logic     bit_tick;                             // sck rise while active
    logic     lr;                                   // 0 sends left and 1 sends right
    sample_t  lft_data;
    sample_t  rgt_data;
    bit_cnt_t bit_count;                            // Bit of the word on the line

    assign rts_rise = filt_i2so_rts && !rts_d;
    assign bit_tick = sck_transition && active;

    // Frame start is the end of a right word
    assign filt_i2so_rtr = bit_tick && (bit_count == '0) && lr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rts_d  <= 1'b0;
            active <= 1'b0;
        end
        else
        begin
            rts_d <= filt_i2so_rts;
            if (rts_rise)
                active <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Word and bit sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lr        <= 1'b1;                      // First rtr then lands on left
            bit_count <= '0;
            lft_data  <= '0;
            rgt_data  <= '0;
        end
        else
        begin
            if (bit_tick && bit_count == '0)
                lr <= ~lr;                          // Channel swap at word end
            if (filt_i2so_rtr)
            begin
                lft_data  <= filt_i2so_lft;         // Both words from one frame
                rgt_data  <= filt_i2so_rgt;
                bit_count <= bit_cnt_t'(SAMPLE_W - 1);
            end
            else if (bit_tick)
                bit_count <= bit_count - 1'b1;      // Wraps to the MSB of the right word
        end
    end

    // Serial outputs
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            i2so_ws <= 1'b0;
            i2so_sd <= 1'b0;
        end
        else
        begin
            if (bit_tick && bit_count == bit_cnt_t'(1))
                i2so_ws <= ~i2so_ws;                // One sck ahead of the next MSB
            if (active)
                i2so_sd <= lr ? rgt_data[bit_count] : lft_data[bit_count];
        end
    end

endmodule

/* rtl/i2s_avg_top.sv */
`timescale 1ns/1ns

module i2s_avg_top (
    input  logic clk,
    input  logic rst_n,
    input  logic i2si_sd,
    input  logic i2si_ws,
    output logic i2s_sck,
    output logic i2so_sd,
    output logic i2so_ws
);

    import audio_pkg::*;
    import mem_pkg::*;

    logic      sck_rise;                            // Shared bit strobe
    // Write client
    logic      wr_req;
    logic      wr_gnt;
    ram_addr_t wr_addr;
    sample_t   wr_data;
    logic      frame_done;
    // Read client
    logic      rd_req;
    logic      rd_gnt;
    ram_addr_t rd_addr;
    sample_t   rd_data;
    // Filter to serializer
    logic      filt_i2so_rts;
    logic      filt_i2so_rtr;
    sample_t   filt_i2so_lft;
    sample_t   filt_i2so_rgt;

    sck_gen i_sck_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .i2s_sck  (i2s_sck),
        .sck_rise (sck_rise)
    );

    i2si_deserializer i_i2si_deserializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck_rise   (sck_rise),
        .i2si_sd    (i2si_sd),
        .i2si_ws    (i2si_ws),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_gnt     (wr_gnt),
        .frame_done (frame_done)
    );

    sample_ram_arb i_sample_ram_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_gnt  (wr_gnt),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_gnt  (rd_gnt)
    );

    avg_filter i_avg_filter (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_done    (frame_done),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_gnt        (rd_gnt),
        .rd_data       (rd_data),
        .filt_i2so_rts (filt_i2so_rts),
        .filt_i2so_lft (filt_i2so_lft),
        .filt_i2so_rgt (filt_i2so_rgt),
        .filt_i2so_rtr (filt_i2so_rtr)
    );

    // Output side runs from the same sck strobe
    i2so_serializer i_i2so_serializer (
        .clk            (clk),
        .rst_n          (rst_n),
        .sck_transition (sck_rise),
        .filt_i2so_rts  (filt_i2so_rts),
        .filt_i2so_rtr  (filt_i2so_rtr),
        .filt_i2so_lft  (filt_i2so_lft),
        .filt_i2so_rgt  (filt_i2so_rgt),
        .i2so_sd        (i2so_sd),
        .i2so_ws        (i2so_ws)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;                     // 20 ns period
    end

    // Reset over three rising edges, released just after the third
    initial
    begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

/* bench/tb_i2s_avg.sv */
`timescale 1ns/1ns

module tb_i2s_avg;

    import audio_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        i2si_sd;
    logic        i2si_ws;
    logic        i2s_sck;
    logic        i2so_sd;
    logic        i2so_ws;

    // Rows 0 to 11 carry audio and rows 12 to 15 stay silent for the decay
    sample_t     stim_l [16];
    sample_t     stim_r [16];
    sample_t     exp_l  [16];
    sample_t     exp_r  [16];

    logic [31:0] lfsr;
    int          err_count;                         // Wrong output values
    int          proto_errors;                      // Framing and lock failures
    int          checked;                           // Frames compared so far
    int          skipped;                           // Silent frames before lock
    logic        locked;
    logic        mon_done;
    // Output decoder state
    logic        sck_d;
    logic        mon_ws;
    sample_t     mon_word;
    sample_t     got_left;
    int          mon_bits;                          // Bits since the last ws change
    int          ws_seen;
    int          sck_cycles;                        // clk cycles since the last sck rise
    int          sck_rises;

    tb_clock i_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    i2s_avg_top i_i2s_avg_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .i2si_sd (i2si_sd),
        .i2si_ws (i2si_ws),
        .i2s_sck (i2s_sck),
        .i2so_sd (i2so_sd),
        .i2so_ws (i2so_ws)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus and reference tables
    ////////////////////////////////////////////////////////////

    // Fibonacci form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic draw_sample(output sample_t value);
        value = '0;
        for (int b = 0; b < SAMPLE_W; b++)
        begin
            lfsr  = lfsr_next(lfsr);                // One step per bit
            value = {value[SAMPLE_W-2:0], lfsr[0]};
        end
    endtask

    task automatic build_tables();
        int sum_l;
        int sum_r;
        for (int f = 0; f < 16; f++)
        begin
            stim_l[f] = '0;
            stim_r[f] = '0;
            if (f < 12)
            begin
                draw_sample(stim_l[f]);
                draw_sample(stim_r[f]);
            end
        end
        stim_l[0] = 16'h7ffc;                       // Large positive
        stim_r[0] = 16'h8000;                       // Full negative
        stim_l[1] = 16'h7fff;                       // Full scale
        stim_r[1] = 16'h8000;
        stim_l[2] = 16'h8001;
        stim_r[2] = 16'h7fff;
        stim_l[3] = 16'hffff;                       // Tiny values with mixed signs
        stim_r[3] = 16'h0001;
        stim_l[8] = 16'h8000;
        stim_r[8] = 16'h7fff;
        stim_l[9] = 16'h5555;                       // Alternating bit patterns
        stim_r[9] = 16'haaaa;
        // Average of the last four frames per channel with zero history before frame 0
        for (int f = 0; f < 16; f++)
        begin
            sum_l = 0;
            sum_r = 0;
            for (int t = 0; t < 4; t++)
            begin
                if (f - t >= 0)
                begin
                    sum_l = sum_l + int'($signed(stim_l[f - t]));
                    sum_r = sum_r + int'($signed(stim_r[f - t]));
                end
            end
            exp_l[f] = sample_t'(sum_l >>> 2);      // Floor divide with sign kept
            exp_r[f] = sample_t'(sum_r >>> 2);
        end
    endtask

    // ws leads the MSB by one bit and data is set while sck is low
    task automatic send_frame(input sample_t left, input sample_t right);
        for (int s = 0; s < 32; s++)
        begin
            @(negedge i2s_sck);
            #2;
            i2si_ws = (s >= 15 && s < 31);
            i2si_sd = (s < 16) ? left[15 - s] : right[31 - s];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Output checking
    ////////////////////////////////////////////////////////////

    task automatic check_frame(input sample_t left, input sample_t right);
        if (!locked && left == exp_l[0] && right == exp_r[0])
            locked = 1'b1;
        if (!locked)
        begin
            assert (left == '0 && right == '0)
            else
            begin
                $display("Output frame before the first average is not silent at %0t", $time);
                proto_errors++;
            end
            skipped++;
            assert (skipped <= 3)
            else
            begin
                $display("First expected average never appeared on the output");
                proto_errors++;
                mon_done = 1'b1;
            end
        end
        else
        begin
            assert (left == exp_l[checked])
            else
            begin
                $display("Fail %0t ns: i2so_sd left frame %0d expected %h got %h",
                         $time, checked, exp_l[checked], left);
                err_count++;
            end
            assert (right == exp_r[checked])
            else
            begin
                $display("Fail %0t ns: i2so_sd right frame %0d expected %h got %h",
                         $time, checked, exp_r[checked], right);
                err_count++;
            end
            checked++;
            if (checked == 16)
                mon_done = 1'b1;
        end
    endtask

    // Sampled on the falling clk after each sck rise
    always @(negedge clk)
    begin
        if (rst_n && !mon_done && i2s_sck && !sck_d)
        begin
            if (sck_rises > 0)
            begin
                assert (sck_cycles == SCK_DIV)
                else
                begin
                    $display("Fail %0t ns: i2s_sck period expected %0d got %0d clk cycles",
                             $time, SCK_DIV, sck_cycles);
                    proto_errors++;
                end
            end
            sck_rises++;
            sck_cycles = 0;
            mon_word = {mon_word[SAMPLE_W-2:0], i2so_sd};
            mon_bits++;
            if (ws_seen == 0)
            begin
                assert (i2so_sd == 1'b0)
                else
                begin
                    $display("i2so_sd went high before the first output word at %0t", $time);
                    proto_errors++;
                end
            end
            if (i2so_ws != mon_ws)                  // This bit is the LSB
            begin
                if (ws_seen > 0)
                begin
                    assert (mon_bits == SAMPLE_W)
                    else
                    begin
                        $display("Fail %0t ns: i2so_ws word length expected %0d got %0d",
                                 $time, SAMPLE_W, mon_bits);
                        proto_errors++;
                    end
                end
                if (mon_ws)
                    check_frame(got_left, mon_word);
                else
                    got_left = mon_word;
                ws_seen++;
                mon_bits = 0;
                mon_ws   = i2so_ws;
            end
        end
        sck_cycles++;
        sck_d = i2s_sck;
    end

    ////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////

    initial
    begin
        i2si_sd      = 1'b0;
        i2si_ws      = 1'b0;
        lfsr         = 32'h836cad17;
        err_count    = 0;
        proto_errors = 0;
        checked      = 0;
        skipped      = 0;
        locked       = 1'b0;
        mon_done     = 1'b0;
        sck_d        = 1'b0;
        mon_ws       = 1'b0;
        mon_word     = '0;
        got_left     = '0;
        mon_bits     = 0;
        ws_seen      = 0;
        sck_cycles   = 0;
        sck_rises    = 0;
        build_tables();
        wait (rst_n === 1'b1);
        for (int f = 0; f < 16; f++)
            send_frame(stim_l[f], stim_r[f]);
        wait (mon_done);
        $display("Errors: %0d value, %0d protocol", err_count, proto_errors);
        if (err_count == 0 && proto_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Table plus four frames of slack at 32 sck of SCK_DIV clocks each
    initial
    begin
        #((16 + 4) * 32 * SCK_DIV * 20);
        $display("Timeout, only %0d of 16 output frames checked", checked);
        $display("Errors: %0d value, %0d protocol", err_count, proto_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
rtl/audio_pkg.sv
rtl/mem_pkg.sv
rtl/sck_gen.sv
rtl/i2si_deserializer.sv
rtl/sample_ram_arb.sv
rtl/avg_filter.sv
rtl/i2so_serializer.sv
rtl/i2s_avg_top.sv
bench/tb_clock.sv
bench/tb_i2s_avg.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_i2s_avg
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
